/* verilog/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    ////////////////////////////////////////////////////////////
    // Address split and array sizes
    ////////////////////////////////////////////////////////////

    localparam int addr_bits  = 32;
    localparam int tag_bits   = 25;
    localparam int index_bits = 4;
    localparam int sets       = 1 << index_bits;
    localparam int ways       = 2;
    localparam int word_bits  = 32;
    localparam int line_words = 2;

    // Derived field widths
    localparam int byte_bits     = 2;
    localparam int word_sel_bits = $clog2(line_words);
    localparam int way_bits      = $clog2(ways);

    ////////////////////////////////////////////////////////////
    // Operations and controller states
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        op_fetch       = 2'd0,
        op_inval_all   = 2'd1,
        op_inval_index = 2'd2,
        op_inval_hit   = 2'd3
    } cache_op_e;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_refill_req,
        st_refill_wait,
        st_respond,
        st_ack_wait
    } ctrl_state_e;

endpackage

`default_nettype wire

/* verilog/tagv_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface tagv_if;
    import icache_pkg::*;

    // Lookup side
    logic [index_bits-1:0] addr_read;
    logic [tag_bits-1:0]   tag_compare;
    logic [ways-1:0]       hit;

    // Update side
    logic                  ibar;
    logic [1:0]            init;
    logic [tag_bits-1:0]   tag_write;
    logic [index_bits-1:0] addr_write;
    logic [ways-1:0]       unvalid;
    logic [ways-1:0]       we;

    modport ctrl (
        output addr_read, tag_compare, ibar, init, tag_write, addr_write, unvalid, we,
        input  hit
    );

    modport tagv (
        input  addr_read, tag_compare, ibar, init, tag_write, addr_write, unvalid, we,
        output hit
    );

endinterface

`default_nettype wire

/* verilog/lutram.sv */
`timescale 1ns/10ps
`default_nettype none

module lutram (
    input  wire                            clk,
    input  wire [icache_pkg::index_bits-1:0] waddr,
    input  wire [icache_pkg::tag_bits-1:0]   din,
    input  wire                            we,
    input  wire [icache_pkg::index_bits-1:0] raddr,
    output logic [icache_pkg::tag_bits-1:0]  dout
);
    import icache_pkg::*;

    logic [tag_bits-1:0] mem [sets];

    // Write lands at the clock edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;
        end
    end

    // Read straight out of the array, no register
    assign dout = mem[raddr];

endmodule

`default_nettype wire

/* verilog/icache_tagv.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_tagv (
    input wire   clk,
    input wire   rstn,
    tagv_if.tagv tagv
);
    import icache_pkg::*;

    logic [sets-1:0]     valid [ways];
    logic [ways-1:0]     valid_rd;
    logic [tag_bits-1:0] tag_rd  [ways];
    logic [tag_bits-1:0] tag_din [ways];
    logic [ways-1:0]     tag_we;
    logic [ways-1:0]     clr_way;
    logic [ways-1:0]     upd_en;
    logic [ways-1:0]     upd_val;
    logic                same_index;

    ////////////////////////////////////////////////////////////
    // Per-way update decode
    ////////////////////////////////////////////////////////////

    // Priority below ibar: init, then unvalid, then we
    always_comb begin
        for (int w = 0; w < ways; w++) begin
            clr_way[w] = tagv.init[1] && (tagv.init[0] == 1'(w));
            tag_we[w]  = tagv.we[w] || clr_way[w];
            tag_din[w] = clr_way[w] ? '0 : tagv.tag_write;
            if (tagv.init[1]) begin
                upd_en[w]  = clr_way[w];
                upd_val[w] = 1'b0;
            end else if (tagv.unvalid[w]) begin
                upd_en[w]  = 1'b1;
                upd_val[w] = 1'b0;
            end else begin
                upd_en[w]  = tagv.we[w];
                upd_val[w] = 1'b1;
            end
        end
    end

    assign same_index = (tagv.addr_write == tagv.addr_read);

    ////////////////////////////////////////////////////////////
    // Valid vectors and registered lookup
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int w = 0; w < ways; w++) begin
                valid[w] <= '0;
            end
            valid_rd <= '0;
        end else begin
            for (int w = 0; w < ways; w++) begin
                if (tagv.ibar) begin
                    valid[w]    <= '0;
                    valid_rd[w] <= 1'b0;
                end else begin
                    if (upd_en[w]) begin
                        valid[w][tagv.addr_write] <= upd_val[w];
                    end
                    // Same-index update bypasses the array
                    if (upd_en[w] && same_index) begin
                        valid_rd[w] <= upd_val[w];
                    end else begin
                        valid_rd[w] <= valid[w][tagv.addr_read];
                    end
                end
            end
        end
    end

    lutram way0 (
        .clk   (clk),
        .waddr (tagv.addr_write),
        .din   (tag_din[0]),
        .we    (tag_we[0]),
        .raddr (tagv.addr_read),
        .dout  (tag_rd[0])
    );

    lutram way1 (
        .clk   (clk),
        .waddr (tagv.addr_write),
        .din   (tag_din[1]),
        .we    (tag_we[1]),
        .raddr (tagv.addr_read),
        .dout  (tag_rd[1])
    );

    always_comb begin
        for (int w = 0; w < ways; w++) begin
            tagv.hit[w] = (tag_rd[w] == tagv.tag_compare) && valid_rd[w];
        end
    end

    // Controller never sets and clears the same way at once
    a_no_we_unvalid: assert property (
        @(posedge clk) disable iff (!rstn) (tagv.unvalid & tagv.we) == '0
    );

endmodule

`default_nettype wire

/* verilog/icache_data.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_data (
    input  wire                                clk,
    input  wire [icache_pkg::index_bits-1:0]    index,
    input  wire [icache_pkg::word_sel_bits-1:0] word_sel,
    input  wire [icache_pkg::way_bits-1:0]      way_sel,
    input  wire                                we,
    input  wire [icache_pkg::word_bits-1:0]     wdata,
    output logic [icache_pkg::word_bits-1:0]    rdata
);
    import icache_pkg::*;

    // One word per way, set and line slot
    logic [word_bits-1:0] mem [ways][sets][line_words];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[way_sel][index][word_sel] <= wdata;
        end
    end

    // Combinational word read
    assign rdata = mem[way_sel][index][word_sel];

endmodule

`default_nettype wire

/* verilog/icache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl (
    input  wire                                 clk,
    input  wire                                 rstn,
    input  wire                                 req,
    input  icache_pkg::cache_op_e               op,
    input  wire [icache_pkg::addr_bits-1:0]     addr,
    output logic                                ack,
    output logic [icache_pkg::word_bits-1:0]    rdata,
    output logic                                mem_req,
    output logic [icache_pkg::addr_bits-1:0]    mem_addr,
    input  wire                                 mem_ack,
    input  wire [icache_pkg::word_bits-1:0]     mem_rdata,
    tagv_if.ctrl                                tagv,
    output logic [icache_pkg::index_bits-1:0]   data_index,
    output logic [icache_pkg::word_sel_bits-1:0] data_word_sel,
    output logic [icache_pkg::way_bits-1:0]     data_way_sel,
    output logic                                data_we,
    output logic [icache_pkg::word_bits-1:0]    data_wdata,
    input  wire [icache_pkg::word_bits-1:0]     data_rdata
);
    import icache_pkg::*;

    localparam int index_lsb = byte_bits + word_sel_bits;

    ctrl_state_e              state;
    cache_op_e                op_q;
    logic [addr_bits-1:0]     addr_q;
    logic [index_bits-1:0]    index_q;
    logic [tag_bits-1:0]      tag_q;
    logic [way_bits-1:0]      way_q;
    logic [way_bits-1:0]      hit_way;
    logic [word_sel_bits-1:0] word_cnt;
    logic [sets-1:0]          lru;
    logic                     lookup;
    logic                     first_fill;

    assign index_q = addr_q[index_lsb +: index_bits];
    assign tag_q   = addr_q[addr_bits-1 -: tag_bits];
    assign hit_way = way_bits'(tagv.hit[1]);
    assign lookup  = (state == st_lookup);

    ////////////////////////////////////////////////////////////
    // Tag/valid drive
    ////////////////////////////////////////////////////////////

    // Valid is sampled at the request edge, so read from the live address in idle
    assign tagv.addr_read   = (state == st_idle) ? addr[index_lsb +: index_bits] : index_q;
    assign tagv.tag_compare = tag_q;
    assign tagv.tag_write   = tag_q;
    assign tagv.addr_write  = index_q;
    assign tagv.ibar        = lookup && (op_q == op_inval_all);
    assign tagv.init        = {lookup && (op_q == op_inval_index), addr_q[0]};
    assign tagv.unvalid     = (lookup && (op_q == op_inval_hit)) ? tagv.hit : '0;

    // Tag and valid are written along with the first refill word
    assign first_fill = data_we && (word_cnt == '0);
    assign tagv.we    = first_fill ? (ways'(1) << way_q) : '0;

    // Data array
    assign data_index    = index_q;
    assign data_way_sel  = way_q;
    assign data_word_sel = (state == st_refill_wait) ? word_cnt
                                                     : addr_q[byte_bits +: word_sel_bits];
    assign data_we       = (state == st_refill_wait) && mem_ack;
    assign data_wdata    = mem_rdata;

    ////////////////////////////////////////////////////////////
    // Operation FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= st_idle;
            ack      <= 1'b0;
            mem_req  <= 1'b0;
            lru      <= '0;
            way_q    <= '0;
            word_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (req) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    if (op_q == op_fetch && tagv.hit == '0) begin
                        // A miss refills the LRU way
                        way_q    <= lru[index_q];
                        word_cnt <= '0;
                        state    <= st_refill_req;
                    end else begin
                        way_q <= hit_way;
                        state <= st_respond;
                    end
                end
                st_refill_req: begin
                    // Previous transfer must be fully closed
                    if (!mem_ack) begin
                        mem_req <= 1'b1;
                        state   <= st_refill_wait;
                    end
                end
                st_refill_wait: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        if (word_cnt == word_sel_bits'(line_words - 1)) begin
                            state <= st_respond;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                            state    <= st_refill_req;
                        end
                    end
                end
                st_respond: begin
                    ack <= 1'b1;
                    // Other way becomes the victim
                    if (op_q == op_fetch) begin
                        lru[index_q] <= ~way_q;
                    end
                    state <= st_ack_wait;
                end
                st_ack_wait: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Request capture, memory address and returned word
    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            op_q   <= op;
            addr_q <= addr;
        end
        if (state == st_refill_req && !mem_ack) begin
            mem_addr <= {addr_q[addr_bits-1:index_lsb], word_cnt, {byte_bits{1'b0}}};
        end
        if (state == st_respond) begin
            rdata <= data_rdata;
        end
    end

    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!rstn) $rose(ack) |-> $past(req)
    );

    a_mem_addr_stable: assert property (
        @(posedge clk) disable iff (!rstn) (mem_req && !mem_ack) |=> $stable(mem_addr)
    );

endmodule

`default_nettype wire

/* verilog/icache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_top (
    input  wire                              clk,
    input  wire                              rstn,
    input  wire                              req,
    input  wire [1:0]                        op,
    input  wire [icache_pkg::addr_bits-1:0]  addr,
    output logic                             ack,
    output logic [icache_pkg::word_bits-1:0] rdata,
    output logic                             mem_req,
    output logic [icache_pkg::addr_bits-1:0] mem_addr,
    input  wire                              mem_ack,
    input  wire [icache_pkg::word_bits-1:0]  mem_rdata
);
    import icache_pkg::*;

    logic [index_bits-1:0]    data_index;
    logic [word_sel_bits-1:0] data_word_sel;
    logic [way_bits-1:0]      data_way_sel;
    logic                     data_we;
    logic [word_bits-1:0]     data_wdata;
    logic [word_bits-1:0]     data_rdata;

    tagv_if tagv_bus ();

    icache_ctrl ctrl_i (
        .clk           (clk),
        .rstn          (rstn),
        .req           (req),
        .op            (cache_op_e'(op)),
        .addr          (addr),
        .ack           (ack),
        .rdata         (rdata),
        .mem_req       (mem_req),
        .mem_addr      (mem_addr),
        .mem_ack       (mem_ack),
        .mem_rdata     (mem_rdata),
        .tagv          (tagv_bus),
        .data_index    (data_index),
        .data_word_sel (data_word_sel),
        .data_way_sel  (data_way_sel),
        .data_we       (data_we),
        .data_wdata    (data_wdata),
        .data_rdata    (data_rdata)
    );

    icache_tagv tagv_i (
        .clk  (clk),
        .rstn (rstn),
        .tagv (tagv_bus)
    );

    icache_data data_i (
        .clk      (clk),
        .index    (data_index),
        .word_sel (data_word_sel),
        .way_sel  (data_way_sel),
        .we       (data_we),
        .wdata    (data_wdata),
        .rdata    (data_rdata)
    );

endmodule

`default_nettype wire

/* bench/icache_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_tb;
    import icache_pkg::*;

    localparam int n_tests = 6;

    logic        clk = 1'b0;
    logic        rstn;
    logic        req;
    logic [1:0]  op;
    logic [31:0] addr;
    logic        ack;
    logic [31:0] rdata;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_ack;
    logic [31:0] mem_rdata;

    int          seed;
    int          delay_tab [64];
    int          hold_max;
    int          xfer_total;
    int          xfer_base;
    int          err_cmp;
    int          err_mem;
    logic [1:0]  exp_op;
    logic [31:0] exp_addr;
    logic        exp_miss;
    logic        ack_seen;
    logic        ack_q;
    logic        req_q;

    // Cache model, one entry per set and way
    logic [24:0] m_tag   [16][2];
    logic        m_valid [16][2];
    logic        m_lru   [16];

    always #50 clk = ~clk;

    icache_top dut_i (
        .clk       (clk),
        .rstn      (rstn),
        .req       (req),
        .op        (op),
        .addr      (addr),
        .ack       (ack),
        .rdata     (rdata),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] mem_data_of(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] mk_addr(input logic [24:0] t, input logic [3:0] s,
                                            input logic w);
        return {t, s, w, 2'b00};
    endfunction

    function automatic logic expect_miss(input logic [31:0] a);
        logic [3:0]  s;
        logic [24:0] t;
        s = a[6:3];
        t = a[31:7];
        return !((m_valid[s][0] && m_tag[s][0] == t) || (m_valid[s][1] && m_tag[s][1] == t));
    endfunction

    task automatic model_apply(input logic [1:0] o, input logic [31:0] a);
        logic [3:0]  s;
        logic [24:0] t;
        logic        w;
        s = a[6:3];
        t = a[31:7];
        case (o)
            op_fetch: begin
                if (m_valid[s][1] && m_tag[s][1] == t) begin
                    w = 1'b1;
                end else if (m_valid[s][0] && m_tag[s][0] == t) begin
                    w = 1'b0;
                end else begin
                    // Refill goes to the LRU way
                    w = m_lru[s];
                    m_tag[s][w]   = t;
                    m_valid[s][w] = 1'b1;
                end
                m_lru[s] = ~w;
            end
            op_inval_all: begin
                for (int i = 0; i < 16; i++) begin
                    m_valid[i][0] = 1'b0;
                    m_valid[i][1] = 1'b0;
                end
            end
            op_inval_index: m_valid[s][a[0]] = 1'b0;
            default: begin
                for (int i = 0; i < 2; i++) begin
                    if (m_valid[s][i] && m_tag[s][i] == t) begin
                        m_valid[s][i] = 1'b0;
                    end
                end
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // Requester side
    ////////////////////////////////////////////////////////////

    // Called 1 ns after a rising edge, returns at the same point
    task automatic run_op(input logic [1:0] o, input logic [31:0] a);
        int hold;
        exp_op    = o;
        exp_addr  = a;
        exp_miss  = (o == op_fetch) && expect_miss(a);
        xfer_base = xfer_total;
        model_apply(o, a);
        hold = $random(seed) & hold_max;
        op   = o;
        addr = a;
        req  = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!ack);
        repeat (hold) begin
            @(posedge clk);
            #1;
        end
        req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (ack);
    endtask

    ////////////////////////////////////////////////////////////
    // Memory responder
    ////////////////////////////////////////////////////////////

    initial begin
        mem_ack    = 1'b0;
        mem_rdata  = '0;
        xfer_total = 0;
        err_mem    = 0;
        forever begin
            @(posedge clk);
            #1;
            if (rstn && mem_req && !mem_ack) begin
                repeat (delay_tab[xfer_total % 64]) @(posedge clk);
                #1;
                // Word 0 first, then word 1 of the same line
                if (mem_addr != {exp_addr[31:3], 1'(xfer_total - xfer_base), 2'b00}) begin
                    $display("MISMATCH at %0t: mem_addr %h for request %h, transfer %0d",
                             $time, mem_addr, exp_addr, xfer_total - xfer_base);
                    err_mem++;
                end
                mem_rdata  = mem_data_of(mem_addr);
                mem_ack    = 1'b1;
                xfer_total = xfer_total + 1;
                do begin
                    @(posedge clk);
                    #1;
                end while (mem_req);
                mem_ack = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Compare at the falling edge, where outputs are settled
    ////////////////////////////////////////////////////////////

    initial begin
        err_cmp  = 0;
        ack_seen = 1'b0;
        ack_q    = 1'b0;
        req_q    = 1'b0;
        forever begin
            @(negedge clk);
            if (ack && !ack_seen) begin
                ack_seen = 1'b1;
                if (exp_op == op_fetch && rdata != mem_data_of(exp_addr)) begin
                    $display("MISMATCH at %0t: addr %h rdata %h expected %h",
                             $time, exp_addr, rdata, mem_data_of(exp_addr));
                    err_cmp++;
                end
                if ((xfer_total - xfer_base) != (exp_miss ? 2 : 0)) begin
                    $display("MISMATCH at %0t: op %0d addr %h made %0d transfers, expected %0d",
                             $time, exp_op, exp_addr, xfer_total - xfer_base,
                             exp_miss ? 2 : 0);
                    err_cmp++;
                end
            end
            if (ack_q && req_q && !ack) begin
                $display("Error at %0t: ack dropped while req was still high", $time);
                err_cmp++;
            end
            if (!ack) begin
                ack_seen = 1'b0;
            end
            ack_q = ack;
            req_q = req;
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] a_a;
        logic [31:0] a_b;
        logic [31:0] t1;
        logic [31:0] t2;
        logic [31:0] t3;
        logic [31:0] p;
        logic [31:0] q;
        logic [31:0] a;
        int          r;
        int          rt;
        int          rs;
        int          rw;
        seed = 32'hafba_3c14;
        for (int i = 0; i < 64; i++) begin
            delay_tab[i] = $random(seed) & 3;
        end
        rstn     = 1'b0;
        req      = 1'b0;
        op       = '0;
        addr     = '0;
        hold_max = 0;
        exp_op   = op_fetch;
        exp_addr = '0;
        exp_miss = 1'b0;
        for (int i = 0; i < 16; i++) begin
            m_valid[i][0] = 1'b0;
            m_valid[i][1] = 1'b0;
            m_tag[i][0]   = '0;
            m_tag[i][1]   = '0;
            m_lru[i]      = 1'b0;
        end
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(posedge clk);
        #1;

        a_a = mk_addr(25'h10, 4'd3, 1'b0);
        a_b = mk_addr(25'h11, 4'd5, 1'b1);
        $display("Test 1: misses after reset");
        run_op(op_fetch, a_a);
        run_op(op_fetch, a_b);

        $display("Test 2: repeated fetches hit");
        run_op(op_fetch, a_a | 32'h4);
        run_op(op_fetch, a_a);
        run_op(op_fetch, a_b);

        // Three tags sharing set 7
        t1 = mk_addr(25'h20, 4'd7, 1'b0);
        t2 = mk_addr(25'h21, 4'd7, 1'b1);
        t3 = mk_addr(25'h22, 4'd7, 1'b0);
        $display("Test 3: LRU eviction");
        run_op(op_fetch, t1);
        run_op(op_fetch, t2);
        run_op(op_fetch, t1);
        run_op(op_fetch, t3);
        run_op(op_fetch, t1);
        run_op(op_fetch, t2);

        $display("Test 4: invalidate all");
        run_op(op_inval_all, '0);
        run_op(op_fetch, a_a);
        run_op(op_fetch, a_b);
        run_op(op_fetch, t2);

        p = mk_addr(25'h30, 4'd9, 1'b0);
        q = mk_addr(25'h31, 4'd9, 1'b0);
        $display("Test 5: index and hit invalidate");
        run_op(op_fetch, p);
        run_op(op_fetch, q);
        run_op(op_inval_index, q | 32'h1);
        run_op(op_fetch, p);
        run_op(op_fetch, q);
        run_op(op_inval_hit, p);
        run_op(op_fetch, q);
        run_op(op_fetch, p);

        $display("Test 6: random mix with slow memory and held req");
        hold_max = 3;
        for (int i = 0; i < 24; i++) begin
            r  = $random(seed) & 7;
            rt = $random(seed) & 3;
            rs = $random(seed) & 1;
            rw = $random(seed) & 1;
            a  = mk_addr(25'h40 + 25'(rt), 4'(2 + rs), 1'(rw));
            if (r == 7) begin
                run_op(op_inval_hit, a);
            end else if (r == 6) begin
                run_op(op_inval_index, a | 32'(rw));
            end else begin
                run_op(op_fetch, a);
            end
        end

        repeat (4) @(posedge clk);
        $display("Errors: compare %0d, memory %0d, total %0d", err_cmp, err_mem,
                 err_cmp + err_mem);
        if (err_cmp + err_mem == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(n_tests * 2000 * 100);
        $display("Timeout: the tests did not finish in time");
        $display("Errors: compare %0d, memory %0d, total %0d", err_cmp, err_mem,
                 err_cmp + err_mem);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
verilog/icache_pkg.sv
verilog/tagv_if.sv
verilog/lutram.sv
verilog/icache_tagv.sv
verilog/icache_data.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
bench/icache_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module icache_tb -f filelist.f

out=$(./obj_dir/Vicache_tb)
echo "$out"
echo "$out" | grep -q "Simulation PASSED"
